/* compile.f */
logic/simsram_pkg.sv
logic/bus_window_decode.sv
logic/sram_bank.sv
logic/rsp_merge.sv
logic/sim_sram_top.sv
dv/sim_sram_asserts.sv
dv/sim_sram_tb.sv

/* Makefile */
# Verilator build and run for the simulation SRAM window.
# Any variable below can be overridden on the command line.

VERILATOR ?= verilator
TOP       ?= sim_sram_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Regression failed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, search the log"
	@echo "  clean  remove the build directory and the log"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/sim_sram_tb.sv */
/*
 * Testbench for the simulation SRAM window.
 * Clock, reset, host driver with a reference model of the window,
 * outbound responder model and in-order response checks.
 */

`default_nettype none

module sim_sram_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import simsram_pkg::*;

  localparam int unsigned    wait_limit = 64;
  localparam logic [31:0]    rsp_xor    = 32'h5a5a_a5a5;

  logic                 clk_i;
  logic                 rst_ni;
  logic                 req_valid_i;
  logic                 req_write_i;
  logic [AddrWidth-1:0] req_addr_i;
  logic [DataWidth-1:0] req_wdata_i;
  logic [MaskWidth-1:0] req_mask_i;
  logic                 req_ready_o;
  logic                 rsp_valid_o;
  logic [DataWidth-1:0] rsp_rdata_o;
  logic                 rsp_error_o;
  logic                 out_req_valid_o;
  logic                 out_req_write_o;
  logic [AddrWidth-1:0] out_req_addr_o;
  logic [DataWidth-1:0] out_req_wdata_o;
  logic [MaskWidth-1:0] out_req_mask_o;
  logic                 out_req_ready_i;
  logic                 out_rsp_valid_i;
  logic [DataWidth-1:0] out_rsp_rdata_i;
  logic                 out_rsp_error_i;

  // Reference model of the window, one entry per word.
  logic [DataWidth-1:0] model_mem [NumBanks*BankDepth];
  // Expected responses in request order.
  logic [DataWidth-1:0] exp_data [$];
  logic                 exp_err [$];

  sim_sram_top dut (.*);

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "Run stopped at %0t ns.", $time);
  endtask

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("error at %0t ns: %s got %h, expected %h",
                                  $time, name, got, exp));
    end
  endtask

  // Called on a falling edge; returns on the falling edge after the accept.
  task automatic host_access(input logic write, input logic [AddrWidth-1:0] addr,
                             input logic [DataWidth-1:0] wdata,
                             input logic [MaskWidth-1:0] mask);
    int unsigned waited;
    logic [5:0]  idx;
    req_valid_i = 1'b1;
    req_write_i = write;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    req_mask_i  = mask;
    waited      = 0;
    #1;
    while (!req_ready_o) begin
      waited++;
      if (waited > wait_limit) begin
        stop_with_failure("Timed out waiting for the host request to be accepted.");
      end
      @(negedge clk_i);
      #1;
    end
    // Accepted at the coming rising edge.
    if ((addr >= SramBase) && (addr < SramBase + SramBytes)) begin
      idx = addr[7:2];
      if (write) begin
        for (int b = 0; b < MaskWidth; b++) begin
          if (mask[b]) begin
            model_mem[idx][8*b +: 8] = wdata[8*b +: 8];
          end
        end
        exp_data.push_back('0);
      end else begin
        exp_data.push_back(model_mem[idx]);
      end
      exp_err.push_back(1'b0);
    end else begin
      // Outbound data and error come from the responder rule.
      exp_data.push_back(addr ^ rsp_xor);
      exp_err.push_back(addr[2]);
    end
    @(negedge clk_i);
  endtask

  task automatic idle_cycles(input int unsigned n);
    req_valid_i = 1'b0;
    repeat (n) @(negedge clk_i);
  endtask

  // Outbound target with random ready and response delays.
  task automatic serve_outbound();
    int unsigned          ready_wait;
    int unsigned          rsp_wait;
    logic [AddrWidth-1:0] addr;
    out_req_ready_i = 1'b0;
    out_rsp_valid_i = 1'b0;
    out_rsp_rdata_i = '0;
    out_rsp_error_i = 1'b0;
    ready_wait      = 0;
    forever begin
      @(negedge clk_i);
      out_rsp_valid_i = 1'b0;
      out_rsp_rdata_i = '0;
      out_rsp_error_i = 1'b0;
      out_req_ready_i = (ready_wait == 0);
      #1;
      if (out_req_valid_o && ready_wait != 0) begin
        ready_wait--;
      end else if (out_req_valid_o) begin
        // Pass-through must leave the request unchanged.
        check_equal("out_req_addr_o", out_req_addr_o, req_addr_i);
        check_equal("out_req_wdata_o", out_req_wdata_o, req_wdata_i);
        check_equal("out_req_write_o", {31'b0, out_req_write_o}, {31'b0, req_write_i});
        check_equal("out_req_mask_o", {28'b0, out_req_mask_o}, {28'b0, req_mask_i});
        addr     = out_req_addr_o;
        rsp_wait = $urandom_range(4, 1);
        @(negedge clk_i);
        out_req_ready_i = 1'b0;
        repeat (rsp_wait - 1) @(negedge clk_i);
        out_rsp_valid_i = 1'b1;
        out_rsp_rdata_i = addr ^ rsp_xor;
        out_rsp_error_i = addr[2];
        ready_wait      = $urandom_range(3, 0);
      end
    end
  endtask

  initial serve_outbound();

  // Response checker sampled in the low clock phase.
  initial begin : rsp_monitor
    forever begin
      @(negedge clk_i);
      #1;
      if (rsp_valid_o) begin
        if (exp_data.size() == 0) begin
          stop_with_failure("A response arrived with no request pending.");
        end
        check_equal("rsp_rdata_o", rsp_rdata_o, exp_data.pop_front());
        check_equal("rsp_error_o", {31'b0, rsp_error_o}, {31'b0, exp_err.pop_front()});
      end
      if (dut.u_asserts.err_count != 0) begin
        stop_with_failure("An assertion on the DUT failed.");
      end
    end
  end

  initial begin : main
    int unsigned          waited;
    logic [AddrWidth-1:0] addr;
    rst_ni      = 1'b0;
    req_valid_i = 1'b0;
    req_write_i = 1'b0;
    req_addr_i  = '0;
    req_wdata_i = '0;
    req_mask_i  = '0;
    void'($urandom(32'h42f3_611c));
    repeat (5) @(posedge clk_i);
    #1;
    check_equal("req_ready_o", {31'b0, req_ready_o}, 32'h0);
    check_equal("rsp_valid_o", {31'b0, rsp_valid_o}, 32'h0);
    check_equal("out_req_valid_o", {31'b0, out_req_valid_o}, 32'h0);
    @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    check_equal("rsp_valid_o", {31'b0, rsp_valid_o}, 32'h0);
    check_equal("out_req_valid_o", {31'b0, out_req_valid_o}, 32'h0);
    @(negedge clk_i);
    // Full words into every bank, then read all back to back.
    for (int w = 0; w < NumBanks * BankDepth; w++) begin
      host_access(1'b1, SramBase + 32'(w * 4), $urandom, 4'hf);
    end
    for (int w = 0; w < NumBanks * BankDepth; w++) begin
      host_access(1'b0, SramBase + 32'(w * 4), '0, 4'h0);
    end
    // Partial byte masks, each word read back at once.
    for (int i = 0; i < 24; i++) begin
      addr = SramBase + 32'(6'($urandom) * 4);
      host_access(1'b1, addr, $urandom, 4'($urandom));
      host_access(1'b0, addr, '0, 4'h0);
    end
    // Pipelined reads at random words.
    for (int i = 0; i < 32; i++) begin
      host_access(1'b0, SramBase + 32'(6'($urandom) * 4), '0, 4'h0);
    end
    // Outbound accesses below and above the window follow a bank read each.
    for (int i = 0; i < 8; i++) begin
      host_access(1'b0, SramBase + 32'(i * 4), '0, 4'h0);
      addr = (i[0] ? 32'h1000_0100 : 32'h0fff_ff00) + 32'(i * 4);
      host_access(i[1], addr, $urandom, 4'($urandom));
    end
    // Random mix of window and outbound traffic.
    for (int i = 0; i < 80; i++) begin
      if ($urandom_range(1, 0) == 0) begin
        addr = SramBase + 32'(6'($urandom) * 4);
      end else begin
        addr = 32'h2000_0000 | (32'($urandom) & 32'h0fff_fffc);
      end
      host_access($urandom_range(1, 0) == 1, addr, $urandom, 4'($urandom));
      idle_cycles($urandom_range(2, 0));
    end
    idle_cycles(0);
    // Drain the open responses.
    waited = 0;
    while (exp_data.size() != 0) begin
      waited++;
      if (waited > wait_limit) begin
        stop_with_failure("Timed out waiting for the last responses.");
      end
      @(negedge clk_i);
    end
    repeat (2) @(negedge clk_i);
    if (dut.u_asserts.err_count != 0) begin
      stop_with_failure("An assertion on the DUT failed.");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule : sim_sram_tb

`default_nettype wire

/* dv/sim_sram_asserts.sv */
/*
 * Concurrent assertions bound to the SRAM window top level.
 * Bank response timing, outbound stall, response accounting and reset state.
 */

`default_nettype none

module sim_sram_asserts (
  input logic clk_i,
  input logic rst_ni,
  input logic req_valid_i,
  input logic req_ready_o,
  input logic rsp_valid_o,
  input logic rsp_error_o,
  input logic out_req_valid_o,
  input logic out_req_ready_i,
  input logic out_rsp_valid_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // Number of failed assertions.
  int unsigned err_count = 0;

  logic       host_acc;
  logic       out_acc;
  logic       bank_acc;
  logic       out_pend_q;
  logic [7:0] open_q;

  // Every host accept is either a bank or an outbound transfer.
  assign host_acc = req_valid_i & req_ready_o;
  assign out_acc  = out_req_valid_o & out_req_ready_i;
  assign bank_acc = host_acc & ~out_acc;

  // Own view of the outbound access and of the open requests.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_pend_q <= 1'b0;
      open_q     <= '0;
    end else begin
      if (out_acc) begin
        out_pend_q <= 1'b1;
      end else if (out_rsp_valid_i) begin
        out_pend_q <= 1'b0;
      end
      open_q <= open_q + {7'b0, host_acc} - {7'b0, rsp_valid_o};
    end
  end

  // A bank answers exactly one cycle after its accept, never with an error.
  bank_rsp_next_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    bank_acc |=> rsp_valid_o && !rsp_error_o)
  else begin
    err_count = err_count + 1;
    $error("Bank response missing in the cycle after its accept.");
  end

  // Host is stalled while an outbound access waits for its response.
  stall_while_out_pend: assert property (@(posedge clk_i) disable iff (!rst_ni)
    out_pend_q |-> !req_ready_o)
  else begin
    err_count = err_count + 1;
    $error("Host request accepted during a pending outbound access.");
  end

  // A response needs an earlier accept that is still open.
  rsp_after_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_o |-> open_q != 8'd0)
  else begin
    err_count = err_count + 1;
    $error("Response without a preceding accepted request.");
  end

  // Quiet outputs in reset.
  quiet_in_reset: assert property (@(posedge clk_i)
    !rst_ni |-> !req_ready_o && !rsp_valid_o && !out_req_valid_o)
  else begin
    err_count = err_count + 1;
    $error("Outputs active during reset.");
  end

endmodule : sim_sram_asserts

bind sim_sram_top sim_sram_asserts u_asserts (
  .clk_i,
  .rst_ni,
  .req_valid_i,
  .req_ready_o,
  .rsp_valid_o,
  .rsp_error_o,
  .out_req_valid_o,
  .out_req_ready_i,
  .out_rsp_valid_i
);

`default_nettype wire

/* logic/sim_sram_top.sv */
/*
 * Simulation SRAM window top level.
 * Window decoder, interleaved bank array and response merger.
 */

`default_nettype none

module sim_sram_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  // Host request.
  input  logic                              req_valid_i,
  input  logic                              req_write_i,
  input  logic [simsram_pkg::AddrWidth-1:0] req_addr_i,
  input  logic [simsram_pkg::DataWidth-1:0] req_wdata_i,
  input  logic [simsram_pkg::MaskWidth-1:0] req_mask_i,
  output logic                              req_ready_o,
  // Host response.
  output logic                              rsp_valid_o,
  output logic [simsram_pkg::DataWidth-1:0] rsp_rdata_o,
  output logic                              rsp_error_o,
  // Outbound request.
  output logic                              out_req_valid_o,
  output logic                              out_req_write_o,
  output logic [simsram_pkg::AddrWidth-1:0] out_req_addr_o,
  output logic [simsram_pkg::DataWidth-1:0] out_req_wdata_o,
  output logic [simsram_pkg::MaskWidth-1:0] out_req_mask_o,
  input  logic                              out_req_ready_i,
  // Outbound response.
  input  logic                              out_rsp_valid_i,
  input  logic [simsram_pkg::DataWidth-1:0] out_rsp_rdata_i,
  input  logic                              out_rsp_error_i
);

  import simsram_pkg::*;

  // Shared bank request bus.
  logic [NumBanks-1:0]                bank_req;
  logic                               bank_we;
  logic [BankAw-1:0]                  bank_addr;
  logic [DataWidth-1:0]               bank_wdata;
  logic [MaskWidth-1:0]               bank_mask;
  // Per-bank responses.
  logic [NumBanks-1:0]                bank_rvalid;
  logic [NumBanks-1:0][DataWidth-1:0] bank_rdata;

  bus_window_decode u_decode (
    .clk_i,
    .rst_ni,
    .req_valid_i,
    .req_write_i,
    .req_addr_i,
    .req_wdata_i,
    .req_mask_i,
    .req_ready_o,
    .out_req_valid_o,
    .out_req_write_o,
    .out_req_addr_o,
    .out_req_wdata_o,
    .out_req_mask_o,
    .out_req_ready_i,
    .out_rsp_valid_i,
    .bank_req_o   (bank_req),
    .bank_we_o    (bank_we),
    .bank_addr_o  (bank_addr),
    .bank_wdata_o (bank_wdata),
    .bank_mask_o  (bank_mask)
  );

  // One bank per word lane.
  for (genvar i = 0; i < NumBanks; i++) begin : gen_bank
    sram_bank u_bank (
      .clk_i,
      .rst_ni,
      .req_i    (bank_req[i]),
      .we_i     (bank_we),
      .addr_i   (bank_addr),
      .wdata_i  (bank_wdata),
      .mask_i   (bank_mask),
      .rvalid_o (bank_rvalid[i]),
      .rdata_o  (bank_rdata[i])
    );
  end : gen_bank

  rsp_merge u_merge (
    .bank_rvalid_i (bank_rvalid),
    .bank_rdata_i  (bank_rdata),
    .out_rsp_valid_i,
    .out_rsp_rdata_i,
    .out_rsp_error_i,
    .rsp_valid_o,
    .rsp_rdata_o,
    .rsp_error_o
  );

endmodule : sim_sram_top

`default_nettype wire

/* logic/rsp_merge.sv */
/*
 * Response merger.
 * Folds the bank strobes and the outbound response into one host response.
 */

`default_nettype none

module rsp_merge (
  input  logic [simsram_pkg::NumBanks-1:0]                             bank_rvalid_i,
  input  logic [simsram_pkg::NumBanks-1:0][simsram_pkg::DataWidth-1:0] bank_rdata_i,
  input  logic                                                         out_rsp_valid_i,
  input  logic [simsram_pkg::DataWidth-1:0]                            out_rsp_rdata_i,
  input  logic                                                         out_rsp_error_i,
  output logic                                                         rsp_valid_o,
  output logic [simsram_pkg::DataWidth-1:0]                            rsp_rdata_o,
  output logic                                                         rsp_error_o
);

  import simsram_pkg::*;

  logic                 any_bank;
  logic [DataWidth-1:0] bank_data;

  // At most one bank answers per cycle.
  // Masking by valid keeps stale bank data off the bus.
  always_comb begin
    any_bank  = 1'b0;
    bank_data = '0;
    for (int b = 0; b < NumBanks; b++) begin
      any_bank = any_bank | bank_rvalid_i[b];
      if (bank_rvalid_i[b]) begin
        bank_data = bank_data | bank_rdata_i[b];
      end
    end
  end

  // Bank and outbound responses never overlap.
  // The decoder spaces their accepts, so a plain OR is enough here.
  assign rsp_valid_o = any_bank | out_rsp_valid_i;
  assign rsp_rdata_o = bank_data | (out_rsp_valid_i ? out_rsp_rdata_i : '0);

  // Banks have no error source.
  assign rsp_error_o = out_rsp_valid_i & out_rsp_error_i;

endmodule : rsp_merge

`default_nettype wire

/* logic/sram_bank.sv */
/*
 * One word-wide SRAM bank with byte-enable writes.
 * Registered read data and a response strobe one cycle after each request.
 */

`default_nettype none

module sram_bank (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              req_i,
  input  logic                              we_i,
  input  logic [simsram_pkg::BankAw-1:0]    addr_i,
  input  logic [simsram_pkg::DataWidth-1:0] wdata_i,
  input  logic [simsram_pkg::MaskWidth-1:0] mask_i,
  output logic                              rvalid_o,
  output logic [simsram_pkg::DataWidth-1:0] rdata_o
);

  import simsram_pkg::*;

  logic [DataWidth-1:0] mem_q [BankDepth];
  logic [DataWidth-1:0] rdata_q;
  logic                 rvalid_q;

  // Byte-masked write.
  // Only the lanes with their enable set change.
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < MaskWidth; b++) begin
        if (mask_i[b]) begin
          mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // Read port.
  // Writes answer with zero data.
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= we_i ? '0 : mem_q[addr_i];
    end
  end

  // Every request gets a strobe, reads and writes alike.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule : sram_bank

`default_nettype wire

/* logic/bus_window_decode.sv */
/*
 * Host request decoder for the SRAM window.
 * Routes hits to one bank, misses to the outbound port,
 * and stalls the host while an outbound access is pending.
 */

`default_nettype none

module bus_window_decode (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // Host request.
  input  logic                                 req_valid_i,
  input  logic                                 req_write_i,
  input  logic [simsram_pkg::AddrWidth-1:0]    req_addr_i,
  input  logic [simsram_pkg::DataWidth-1:0]    req_wdata_i,
  input  logic [simsram_pkg::MaskWidth-1:0]    req_mask_i,
  output logic                                 req_ready_o,
  // Outbound request and response strobe.
  output logic                                 out_req_valid_o,
  output logic                                 out_req_write_o,
  output logic [simsram_pkg::AddrWidth-1:0]    out_req_addr_o,
  output logic [simsram_pkg::DataWidth-1:0]    out_req_wdata_o,
  output logic [simsram_pkg::MaskWidth-1:0]    out_req_mask_o,
  input  logic                                 out_req_ready_i,
  input  logic                                 out_rsp_valid_i,
  // Bank request, one select line per bank.
  output logic [simsram_pkg::NumBanks-1:0]     bank_req_o,
  output logic                                 bank_we_o,
  output logic [simsram_pkg::BankAw-1:0]       bank_addr_o,
  output logic [simsram_pkg::DataWidth-1:0]    bank_wdata_o,
  output logic [simsram_pkg::MaskWidth-1:0]    bank_mask_o
);

  import simsram_pkg::*;

  decode_state_e         state_q;
  decode_state_e         state_d;
  logic                  bank_acc_q;
  logic                  hit;
  logic                  bank_go;
  logic                  out_go;
  logic [AddrWidth-1:0]  win_offset;
  logic [BankSelW-1:0]   bank_sel;

  // Window hit.
  // The offset wraps for addresses below the base, so one compare covers both bounds.
  assign win_offset = req_addr_i - SramBase;
  assign hit        = (win_offset < SramBytes);

  // Word-interleaved mapping above the byte offset.
  assign bank_sel    = req_addr_i[$clog2(MaskWidth) +: BankSelW];
  assign bank_addr_o = req_addr_i[$clog2(MaskWidth) + BankSelW +: BankAw];

  // Banks never stall, so a hit in IDLE is accepted at once.
  assign bank_go = req_valid_i & hit & (state_q == IDLE);

  // Outbound issue waits one cycle after a bank accept.
  assign out_req_valid_o = req_valid_i & ~hit & (state_q == IDLE) & ~bank_acc_q;
  assign out_go          = out_req_valid_o & out_req_ready_i;

  assign req_ready_o = bank_go | out_go;

  // Misses pass through unchanged.
  assign out_req_write_o = req_write_i;
  assign out_req_addr_o  = req_addr_i;
  assign out_req_wdata_o = req_wdata_i;
  assign out_req_mask_o  = req_mask_i;

  // One-hot bank select.
  assign bank_req_o   = bank_go ? (NumBanks'(1) << bank_sel) : '0;
  assign bank_we_o    = req_write_i;
  assign bank_wdata_o = req_wdata_i;
  assign bank_mask_o  = req_mask_i;

  // Leave IDLE on an outbound transfer, return on its response.
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:     if (out_go) state_d = OUT_PEND;
      OUT_PEND: if (out_rsp_valid_i) state_d = IDLE;
      default:  state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      bank_acc_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      bank_acc_q <= bank_go;
    end
  end

endmodule : bus_window_decode

`default_nettype wire

/* logic/simsram_pkg.sv */
/*
 * Shared definitions for the simulation SRAM window.
 * Bus widths, bank geometry, window map and decoder states.
 */

`default_nettype none

package simsram_pkg;

  // Host and outbound bus widths.
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned MaskWidth = DataWidth / 8;

  // Bank geometry.
  // Banks are word-interleaved, so the bank select sits right above the byte offset.
  localparam int unsigned NumBanks  = 4;
  localparam int unsigned BankDepth = 16;
  localparam int unsigned BankAw    = 4;
  localparam int unsigned BankSelW  = 2;

  // Address window served by the local banks.
  localparam logic [AddrWidth-1:0] SramBase = 32'h1000_0000;
  // One word is four bytes wide.
  localparam logic [AddrWidth-1:0] SramBytes = NumBanks * BankDepth * 4;

  // Decoder states.
  // OUT_PEND means one outbound access is waiting for its response.
  typedef enum logic [0:0] {
    IDLE     = 1'b0,
    OUT_PEND = 1'b1
  } decode_state_e;

endpackage : simsram_pkg

`default_nettype wire
